// File: logic/branch_condition.sv
`timescale 1ns/100ps

module branch_condition (
  input  logic [3:0]         cond,
  input  cpu_ctrl_pkg::ccr_t ccr,
  output logic               taken
);

  logic carry, negative, overflow, zero;
  logic lt_signed;

  assign {carry, negative, overflow, zero} = ccr;
  assign lt_signed = negative ^ overflow;

  always_comb begin
    case (cond)
      4'd0:    taken = 1'b1;               // bra
      4'd1:    taken = zero;               // eq
      4'd2:    taken = ~zero;              // ne
      4'd3:    taken = ~(zero | carry);    // gtu
      4'd4:    taken = ~(zero | lt_signed); // gt
      4'd5:    taken = ~lt_signed;         // ge
      4'd6:    taken = zero | lt_signed;   // le
      4'd7:    taken = lt_signed;          // lt
      4'd8:    taken = ~carry;             // geu
      4'd9:    taken = carry;              // ltu
      4'd10:   taken = carry | zero;       // leu
      default: taken = 1'b0;               // brn and unused codes
    endcase
  end

endmodule

// File: logic/cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
  input  logic                         clock,
  input  logic                         reset_n,
  input  cpu_ctrl_pkg::instr_word_t    ir,
  input  cpu_ctrl_pkg::ccr_t           ccr,
  input  logic                         bus_wait,
  input  cpu_ctrl_pkg::exc_cause_t     interrupt,
  input  logic [1:0]                   bus_align,
  output cpu_ctrl_pkg::datapath_ctrl_t dp_ctrl,
  output cpu_ctrl_pkg::regfile_ctrl_t  rf_ctrl,
  output cpu_ctrl_pkg::bus_ctrl_t      bus_ctrl,
  output cpu_ctrl_pkg::exc_cause_t     exception
);

  import cpu_ctrl_pkg::*;

  decoded_instr_t decoded;
  logic [3:0]     branch_cond;
  logic           taken;

  instr_decoder u_decoder (
    .ir      (ir),
    .decoded (decoded)
  );

  branch_condition u_branch (
    .cond  (branch_cond),
    .ccr   (ccr),
    .taken (taken)
  );

  ctrl_sequencer u_sequencer (
    .clock       (clock),
    .reset_n     (reset_n),
    .decoded     (decoded),
    .taken       (taken),
    .bus_wait    (bus_wait),
    .interrupt   (interrupt),
    .bus_align   (bus_align),
    .branch_cond (branch_cond),
    .dp_ctrl     (dp_ctrl),
    .rf_ctrl     (rf_ctrl),
    .bus_ctrl    (bus_ctrl),
    .exception   (exception)
  );

endmodule

// File: logic/cpu_ctrl_params.svh
`ifndef CPU_CTRL_PARAMS_SVH
`define CPU_CTRL_PARAMS_SVH

// addressing modes, ir[31:30]
`define MODE_REG        2'h0
`define MODE_REGIND     2'h1
`define MODE_IMM        2'h2
`define MODE_DIR        2'h3

// register mode
`define OP_NOP          7'h00
`define OP_CMP          7'h09
`define OP_MOV          7'h0a
`define OP_COM          7'h0b
`define OP_NEG          7'h0c
`define OP_ALU_REG_HI   3'h2   // 0x20-0x2f, low bits are the ALU function

// register-indirect mode
`define OP_ST_L         7'h00
`define OP_LD_L         7'h01
`define OP_ST_H         7'h02
`define OP_LD_H         7'h03
`define OP_ST_B         7'h04
`define OP_LD_B         7'h05
`define OP_JMP          7'h09

// immediate mode, branches run from bra at 0x00 up to brn
`define OP_BRN          7'h0b
`define OP_LDIU         7'h0c

// direct mode
`define OP_ALU_IMM_HI   3'h0   // 0x00-0x0f
`define OP_TRAP         7'h32

`define PCSEL_INC       3'h1
`define PCSEL_MAR       3'h2
`define PCSEL_BRANCH    3'h3
`define PCSEL_ALU       3'h4
`define PCSEL_VECTOR    3'h5

`define ALU2SEL_REG     3'h0
`define ALU2SEL_SIMM    3'h1
`define ALU2SEL_FOUR    3'h4

`define REGSEL_ALU      4'h0
`define REGSEL_MDR      4'h1
`define REGSEL_NEG      4'h2
`define REGSEL_COM      4'h3
`define REGSEL_MOV      4'h4
`define REGSEL_UIMM     4'h6

`define MDRSEL_BUS      3'h1
`define MDRSEL_RA       3'h3
`define MDRSEL_PC       3'h6

`define MARSEL_BUS      2'h1
`define MARSEL_ALU      2'h2

`define ALU_ADD         3'h2
`define ALU_SUB         3'h3

`define REG_SP          4'hf
`define EXC_BAD_OPCODE  4'h3

`endif

// File: logic/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef logic [31:0] instr_word_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [3:0]  ccr_t;        // carry, negative, overflow, zero
  typedef logic [3:0]  exc_cause_t;  // 0 reset, 1-7 irq, 8-15 trap
  typedef logic [3:0]  byte_lanes_t;
  typedef logic [2:0]  alu_func_t;
  typedef logic [1:0]  mode_t;
  typedef logic [6:0]  opcode_t;

  typedef enum logic [1:0] {
    state_reset,
    state_exception,
    state_fetch,
    state_execute
  } ctrl_state_e;

  typedef enum logic [3:0] {
    class_nop,
    class_alu_reg,
    class_alu_imm,
    class_cmp,
    class_unary,
    class_branch,
    class_ldiu,
    class_load,
    class_store,
    class_jmp,
    class_trap,
    class_illegal
  } instr_class_e;

  typedef enum logic [1:0] {
    size_long,
    size_half,
    size_byte
  } access_size_e;

  typedef struct packed {
    alu_func_t  alu_func;
    logic [2:0] alu2sel;
    logic [3:0] regsel;
    logic [2:0] mdrsel;
    logic [1:0] marsel;
    logic [2:0] pcsel;
    logic       ccr_write;
    logic       ir_write;
    logic       addrsel;   // 0 PC, 1 MAR
  } datapath_ctrl_t;

  typedef struct packed {
    reg_addr_t read_addr1;
    reg_addr_t read_addr2;
    reg_addr_t write_addr;
    logic      write;
  } regfile_ctrl_t;

  typedef struct packed {
    logic        read;
    logic        write;
    byte_lanes_t byteenable;
  } bus_ctrl_t;

  typedef struct packed {
    instr_class_e iclass;
    alu_func_t    alu_func;
    access_size_e size;
    logic [3:0]   branch_cond;
    reg_addr_t    ra;
    reg_addr_t    rb;
    reg_addr_t    rc;
    logic [3:0]   unary_regsel;
    logic [2:0]   trap_code;
  } decoded_instr_t;

endpackage

// File: logic/ctrl_sequencer.sv
`timescale 1ns/100ps
`include "cpu_ctrl_params.svh"

module ctrl_sequencer (
  input  logic                         clock,
  input  logic                         reset_n,
  input  cpu_ctrl_pkg::decoded_instr_t decoded,
  input  logic                         taken,
  input  logic                         bus_wait,
  input  cpu_ctrl_pkg::exc_cause_t     interrupt,
  input  logic [1:0]                   bus_align,
  output logic [3:0]                   branch_cond,
  output cpu_ctrl_pkg::datapath_ctrl_t dp_ctrl,
  output cpu_ctrl_pkg::regfile_ctrl_t  rf_ctrl,
  output cpu_ctrl_pkg::bus_ctrl_t      bus_ctrl,
  output cpu_ctrl_pkg::exc_cause_t     exception
);

  import cpu_ctrl_pkg::*;

  ctrl_state_e state, state_next;
  logic [2:0]  step, step_next;
  exc_cause_t  cause, cause_next;
  byte_lanes_t lanes;

  assign branch_cond = decoded.branch_cond;
  assign exception   = cause;

  // lane 3 is the byte at alignment 0
  always_comb begin
    case (decoded.size)
      size_half: lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      size_byte: lanes = 4'b1000 >> bus_align;
      default:   lanes = 4'b1111;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= state_reset;
      step  <= '0;
      cause <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
      cause <= cause_next;
    end
  end

  always_comb begin
    state_next = state;
    step_next  = step;
    cause_next = cause;

    dp_ctrl          = '0;
    dp_ctrl.alu_func = `ALU_ADD;
    rf_ctrl.read_addr1 = decoded.ra;
    rf_ctrl.read_addr2 = decoded.rb;
    rf_ctrl.write_addr = decoded.ra;
    rf_ctrl.write      = 1'b0;
    bus_ctrl.read       = 1'b0;
    bus_ctrl.write      = 1'b0;
    bus_ctrl.byteenable = 4'b1111;

    case (state)
      state_reset: begin
        cause_next = '0;
        state_next = state_exception;
        step_next  = 3'h3;               // no PC push on reset
      end
      state_exception: begin
        case (step)
          3'h0: begin                    // SP - 4, PC into MDR
            dp_ctrl.alu2sel    = `ALU2SEL_FOUR;
            dp_ctrl.alu_func   = `ALU_SUB;
            dp_ctrl.mdrsel     = `MDRSEL_PC;
            rf_ctrl.read_addr1 = `REG_SP;
            step_next = 3'h1;
          end
          3'h1: begin
            dp_ctrl.marsel     = `MARSEL_ALU;
            dp_ctrl.addrsel    = 1'b1;
            rf_ctrl.write_addr = `REG_SP;
            rf_ctrl.write      = 1'b1;
            bus_ctrl.write     = 1'b1;
            step_next = 3'h2;
          end
          3'h2: begin
            dp_ctrl.addrsel = 1'b1;
            bus_ctrl.write  = 1'b1;
            if (!bus_wait)
              step_next = 3'h3;
          end
          3'h3: begin
            dp_ctrl.pcsel = `PCSEL_VECTOR;
            step_next = 3'h4;
          end
          3'h4: begin                    // read the handler address
            bus_ctrl.read = 1'b1;
            if (!bus_wait)
              step_next = 3'h5;
          end
          3'h5: begin
            bus_ctrl.read  = 1'b1;
            dp_ctrl.marsel = `MARSEL_BUS;
            step_next = 3'h6;
          end
          default: begin
            dp_ctrl.pcsel = `PCSEL_MAR;
            step_next  = '0;
            state_next = state_fetch;
          end
        endcase
      end
      state_fetch: begin
        case (step)
          3'h0: begin
            bus_ctrl.read = 1'b1;
            if (|interrupt) begin
              cause_next = interrupt;
              state_next = state_exception;
            end else if (!bus_wait) begin
              step_next = 3'h1;
            end
          end
          3'h1: begin
            bus_ctrl.read    = 1'b1;
            dp_ctrl.ir_write = 1'b1;
            step_next = 3'h2;
          end
          default: begin
            dp_ctrl.pcsel = `PCSEL_INC;
            step_next  = '0;
            state_next = state_execute;
          end
        endcase
      end
      default: begin
        dp_ctrl.alu_func = decoded.alu_func;
        case (decoded.iclass)
          class_nop: state_next = state_fetch;
          class_alu_reg, class_alu_imm: begin
            rf_ctrl.read_addr1 = decoded.rb;
            if (decoded.iclass == class_alu_imm)
              dp_ctrl.alu2sel = `ALU2SEL_SIMM;
            else
              rf_ctrl.read_addr2 = decoded.rc;
            if (step == 3'h0) begin
              step_next = 3'h1;
            end else begin
              rf_ctrl.write = 1'b1;      // rA <= ALU result
              step_next  = '0;
              state_next = state_fetch;
            end
          end
          class_cmp: begin
            dp_ctrl.ccr_write = 1'b1;
            state_next = state_fetch;
          end
          class_unary: begin
            dp_ctrl.regsel = decoded.unary_regsel;
            rf_ctrl.write  = 1'b1;
            state_next = state_fetch;
          end
          class_branch: begin
            if (taken)
              dp_ctrl.pcsel = `PCSEL_BRANCH;
            state_next = state_fetch;
          end
          class_ldiu: begin
            dp_ctrl.regsel = `REGSEL_UIMM;
            rf_ctrl.write  = 1'b1;
            state_next = state_fetch;
          end
          class_load, class_store: begin
            dp_ctrl.addrsel     = 1'b1;
            bus_ctrl.byteenable = lanes;
            case (step)
              3'h0: begin                // rB + offset
                rf_ctrl.read_addr1 = decoded.rb;
                dp_ctrl.alu2sel    = `ALU2SEL_SIMM;
                step_next = 3'h1;
              end
              3'h1: begin
                dp_ctrl.marsel = `MARSEL_ALU;
                if (decoded.iclass == class_store)
                  dp_ctrl.mdrsel = `MDRSEL_RA;
                step_next = 3'h2;
              end
              3'h2: begin
                if (decoded.iclass == class_store) begin
                  bus_ctrl.write = 1'b1;
                end else begin
                  bus_ctrl.read  = 1'b1;
                  dp_ctrl.mdrsel = `MDRSEL_BUS;
                end
                if (!bus_wait)
                  step_next = 3'h3;
              end
              default: begin
                if (decoded.iclass == class_load) begin
                  dp_ctrl.regsel = `REGSEL_MDR;
                  rf_ctrl.write  = 1'b1;
                end
                step_next  = '0;
                state_next = state_fetch;
              end
            endcase
          end
          class_jmp: begin
            if (step == 3'h0) begin
              rf_ctrl.read_addr1 = decoded.rb;
              dp_ctrl.alu2sel    = `ALU2SEL_SIMM;
              step_next = 3'h1;
            end else begin
              dp_ctrl.pcsel = `PCSEL_ALU;
              step_next  = '0;
              state_next = state_fetch;
            end
          end
          class_trap: begin
            cause_next = {1'b1, decoded.trap_code}; // software traps sit at 8-15
            step_next  = '0;
            state_next = state_exception;
          end
          default: begin
            cause_next = `EXC_BAD_OPCODE;
            step_next  = '0;
            state_next = state_exception;
          end
        endcase
      end
    endcase
  end

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/100ps
`include "cpu_ctrl_params.svh"

module instr_decoder (
  input  cpu_ctrl_pkg::instr_word_t    ir,
  output cpu_ctrl_pkg::decoded_instr_t decoded
);

  import cpu_ctrl_pkg::*;

  mode_t   mode;
  opcode_t op;

  assign mode = ir[31:30];

  // opcode field width depends on the mode
  always_comb begin
    case (mode)
      `MODE_REG: op = ir[29:23];
      `MODE_DIR: op = {1'b0, ir[29:24]};
      default:   op = {3'b000, ir[29:26]};
    endcase
  end

  always_comb begin
    decoded.iclass       = class_illegal;
    decoded.alu_func     = `ALU_ADD;       // address arithmetic
    decoded.size         = size_long;
    decoded.branch_cond  = op[3:0];
    decoded.ra           = ir[19:16];
    decoded.rb           = ir[15:12];
    decoded.rc           = ir[11:8];
    decoded.unary_regsel = `REGSEL_MOV;
    decoded.trap_code    = ir[2:0];

    case (mode)
      `MODE_REG: begin
        if (op == `OP_NOP) begin
          decoded.iclass = class_nop;
        end else if (op == `OP_CMP) begin
          decoded.iclass   = class_cmp;
          decoded.alu_func = `ALU_SUB;
        end else if (op == `OP_MOV || op == `OP_COM || op == `OP_NEG) begin
          decoded.iclass = class_unary;
          if (op == `OP_COM)
            decoded.unary_regsel = `REGSEL_COM;
          else if (op == `OP_NEG)
            decoded.unary_regsel = `REGSEL_NEG;
        end else if (op[6:4] == `OP_ALU_REG_HI) begin
          decoded.iclass   = class_alu_reg;
          decoded.alu_func = op[2:0];
        end
      end
      `MODE_REGIND: begin
        case (op)
          `OP_ST_L, `OP_ST_H, `OP_ST_B: decoded.iclass = class_store;
          `OP_LD_L, `OP_LD_H, `OP_LD_B: decoded.iclass = class_load;
          `OP_JMP:                      decoded.iclass = class_jmp;
          default:                      decoded.iclass = class_illegal;
        endcase
        case (op[2:1])                 // pairs st/ld per size
          2'b00:   decoded.size = size_long;
          2'b01:   decoded.size = size_half;
          default: decoded.size = size_byte;
        endcase
      end
      `MODE_IMM: begin
        if (op <= `OP_BRN)
          decoded.iclass = class_branch;
        else if (op == `OP_LDIU)
          decoded.iclass = class_ldiu;
      end
      default: begin
        if (op[6:4] == `OP_ALU_IMM_HI) begin
          decoded.iclass   = class_alu_imm;
          decoded.alu_func = op[2:0];
        end else if (op == `OP_TRAP) begin
          decoded.iclass = class_trap;
        end
      end
    endcase
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run tb_cpu_control with Verilator, nonzero exit on failure

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module tb_cpu_control -Mdir obj_dir -f vlog.f > build.log 2>&1; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

if ! ./obj_dir/Vtb_cpu_control > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

cat sim.log
if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verification/tb_cpu_control_model.svh
// instruction class from the opcode map of each addressing mode
function automatic instr_class_e expected_class(instr_word_t word);
  opcode_t reg_op;
  opcode_t short_op;   // register-indirect and immediate
  opcode_t dir_op;
  reg_op   = word[29:23];
  short_op = {3'b000, word[29:26]};
  dir_op   = {1'b0, word[29:24]};
  if (word[31:30] == `MODE_REG) begin
    if (reg_op == `OP_NOP)
      return class_nop;
    if (reg_op == `OP_CMP)
      return class_cmp;
    if (reg_op inside {`OP_MOV, `OP_COM, `OP_NEG})
      return class_unary;
    if (reg_op >= 7'h20 && reg_op <= 7'h2f)
      return class_alu_reg;
  end else if (word[31:30] == `MODE_REGIND) begin
    if (short_op <= `OP_LD_B)
      return short_op[0] ? class_load : class_store;
    if (short_op == `OP_JMP)
      return class_jmp;
  end else if (word[31:30] == `MODE_IMM) begin
    if (short_op <= `OP_BRN)
      return class_branch;
    if (short_op == `OP_LDIU)
      return class_ldiu;
  end else begin
    if (dir_op <= 7'h0f)
      return class_alu_imm;
    if (dir_op == `OP_TRAP)
      return class_trap;
  end
  return class_illegal;
endfunction

function automatic access_size_e expected_size(instr_word_t word);
  if (word[29:26] < 4'd2)
    return size_long;
  if (word[29:26] < 4'd4)
    return size_half;
  return size_byte;
endfunction

function automatic byte_lanes_t expected_lanes(access_size_e size, logic [1:0] align);
  if (size == size_long)
    return 4'b1111;
  if (size == size_half)
    return align[1] ? 4'b0011 : 4'b1100;
  case (align)
    2'd0:    return 4'b1000;     // top lane first
    2'd1:    return 4'b0100;
    2'd2:    return 4'b0010;
    default: return 4'b0001;
  endcase
endfunction

function automatic logic branch_taken(logic [3:0] cond, ccr_t flags);
  logic c, n, v, z;
  {c, n, v, z} = flags;
  case (cond)
    4'd0:    return 1'b1;
    4'd1:    return z;
    4'd2:    return !z;
    4'd3:    return !z && !c;
    4'd4:    return !z && (n == v);
    4'd5:    return n == v;
    4'd6:    return z || (n != v);
    4'd7:    return n != v;
    4'd8:    return !c;
    4'd9:    return c;
    4'd10:   return c || z;
    default: return 1'b0;    // brn
  endcase
endfunction

function automatic logic [3:0] unary_regsel(opcode_t op);
  if (op == `OP_COM)
    return `REGSEL_COM;
  if (op == `OP_NEG)
    return `REGSEL_NEG;
  return `REGSEL_MOV;
endfunction

task automatic check_dp(string what, datapath_ctrl_t got, datapath_ctrl_t want,
                        datapath_ctrl_t mask);
  if ((got & mask) !== (want & mask)) begin
    errors++;
    $display("Error: dp_ctrl at %s got 0x%h, expected 0x%h", what, got & mask, want & mask);
  end
endtask

task automatic check_rf(string what, regfile_ctrl_t got, regfile_ctrl_t want,
                        regfile_ctrl_t mask);
  if ((got & mask) !== (want & mask)) begin
    errors++;
    $display("Error: rf_ctrl at %s got 0x%h, expected 0x%h", what, got & mask, want & mask);
  end
endtask

task automatic check_bus(string what, bus_ctrl_t got, bus_ctrl_t want, bus_ctrl_t mask);
  if ((got & mask) !== (want & mask)) begin
    errors++;
    $display("Error: bus_ctrl at %s got 0x%h, expected 0x%h", what, got & mask, want & mask);
  end
endtask

task automatic check_cause(string what, exc_cause_t got, exc_cause_t want);
  if (got !== want) begin
    errors++;
    $display("Error: exception at %s got 0x%h, expected 0x%h", what, got, want);
  end
endtask

// every strobe inactive, selects not looked at
task automatic expect_idle();
  dp_exp             = '0;
  dp_mask            = '0;
  dp_mask.pcsel      = '1;
  dp_mask.ccr_write  = 1'b1;
  dp_mask.ir_write   = 1'b1;
  rf_exp             = '0;
  rf_mask            = '0;
  rf_mask.write      = 1'b1;
  bus_exp            = '0;
  bus_mask           = '0;
  bus_mask.read      = 1'b1;
  bus_mask.write     = 1'b1;
endtask

task automatic want_write(reg_addr_t addr, logic [3:0] regsel);
  rf_exp.write       = 1'b1;
  rf_exp.write_addr  = addr;
  rf_mask.write_addr = '1;
  dp_exp.regsel      = regsel;
  dp_mask.regsel     = '1;
endtask

task automatic want_offset(reg_addr_t base);   // base register plus immediate
  rf_exp.read_addr1  = base;
  rf_mask.read_addr1 = '1;
  dp_exp.alu2sel     = `ALU2SEL_SIMM;
  dp_mask.alu2sel    = '1;
endtask

task automatic check_outputs(string what);
  check_dp(what, dp_ctrl, dp_exp, dp_mask);
  check_rf(what, rf_ctrl, rf_exp, rf_mask);
  check_bus(what, bus_ctrl, bus_exp, bus_mask);
  check_cause(what, exception, cause_exp);
endtask

// File: verification/tb_cpu_control.sv
`timescale 1ns/100ps
`include "cpu_ctrl_params.svh"

module tb_cpu_control;

  import cpu_ctrl_pkg::*;

  logic           clock;
  logic           reset_n;
  instr_word_t    ir;
  ccr_t           ccr;
  logic           bus_wait;
  exc_cause_t     interrupt;
  logic [1:0]     bus_align;
  datapath_ctrl_t dp_ctrl;
  regfile_ctrl_t  rf_ctrl;
  bus_ctrl_t      bus_ctrl;
  exc_cause_t     exception;

  datapath_ctrl_t dp_exp, dp_mask;
  regfile_ctrl_t  rf_exp, rf_mask;
  bus_ctrl_t      bus_exp, bus_mask;
  exc_cause_t     cause_exp;
  int             wait_run;          // bus_wait cycles in a row
  int             errors;
  int             errors_at_start;
  int             tests_run;
  int             tests_failed;
  logic           hung;

  cpu_control u_dut (
    .clock     (clock),
    .reset_n   (reset_n),
    .ir        (ir),
    .ccr       (ccr),
    .bus_wait  (bus_wait),
    .interrupt (interrupt),
    .bus_align (bus_align),
    .dp_ctrl   (dp_ctrl),
    .rf_ctrl   (rf_ctrl),
    .bus_ctrl  (bus_ctrl),
    .exception (exception)
  );

  `include "tb_cpu_control_model.svh"

  always #2 clock = ~clock;

  // memory side wait of three cycles at most
  always @(posedge clock) begin
    if (wait_run < 3 && ($urandom % 3) == 0) begin
      bus_wait <= 1'b1;
      wait_run <= wait_run + 1;
    end else begin
      bus_wait <= 1'b0;
      wait_run <= 0;
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    @(negedge clock);
  endtask

  // checks a bus step until bus_wait drops
  task automatic check_bus_step(string what);
    int n;
    n = 0;
    check_outputs(what);
    while (bus_wait && !hung) begin
      if (n == 200) begin
        hung = 1'b1;
        $display("timeout: bus_wait kept %s from finishing for 200 cycles", what);
      end else begin
        n++;
        next_cycle();
        check_outputs(what);
      end
    end
  endtask

  task automatic vector_load_check();
    next_cycle();
    expect_idle();
    dp_exp.pcsel = `PCSEL_VECTOR;
    check_outputs("vector select");
    next_cycle();
    expect_idle();
    bus_exp.read    = 1'b1;
    dp_mask.addrsel = 1'b1;            // vector read from PC
    check_bus_step("vector read");
    next_cycle();
    expect_idle();
    bus_exp.read   = 1'b1;
    dp_exp.marsel  = `MARSEL_BUS;
    dp_mask.marsel = '1;
    check_outputs("vector to mar");
    next_cycle();
    expect_idle();
    dp_exp.pcsel = `PCSEL_MAR;
    check_outputs("pc from mar");
  endtask

  task automatic push_pc_check(exc_cause_t cause);
    next_cycle();
    cause_exp = cause;
    expect_idle();
    dp_exp.alu_func    = `ALU_SUB;
    dp_mask.alu_func   = '1;
    dp_exp.alu2sel     = `ALU2SEL_FOUR;
    dp_mask.alu2sel    = '1;
    dp_exp.mdrsel      = `MDRSEL_PC;
    dp_mask.mdrsel     = '1;
    rf_exp.read_addr1  = `REG_SP;
    rf_mask.read_addr1 = '1;
    check_outputs("sp minus four");
    next_cycle();
    expect_idle();
    rf_exp.write       = 1'b1;
    rf_exp.write_addr  = `REG_SP;
    rf_mask.write_addr = '1;
    bus_exp.write      = 1'b1;
    dp_exp.addrsel     = 1'b1;
    dp_mask.addrsel    = 1'b1;
    check_outputs("sp write");
    next_cycle();
    expect_idle();
    bus_exp.write   = 1'b1;
    dp_exp.addrsel  = 1'b1;
    dp_mask.addrsel = 1'b1;
    check_bus_step("pc push");
    vector_load_check();
  endtask

  task automatic fetch_check(instr_word_t word, logic [1:0] align, ccr_t flags);
    @(posedge clock);
    ir        <= word;
    interrupt <= '0;
    bus_align <= align;
    ccr       <= flags;
    @(negedge clock);
    expect_idle();
    bus_exp.read    = 1'b1;
    dp_mask.addrsel = 1'b1;            // address from PC
    check_bus_step("fetch read");
    next_cycle();
    expect_idle();
    bus_exp.read    = 1'b1;
    dp_exp.ir_write = 1'b1;
    check_outputs("ir write");
    next_cycle();
    expect_idle();
    dp_exp.pcsel = `PCSEL_INC;
    check_outputs("pc increment");
  endtask

  task automatic execute_check(instr_word_t word, logic [1:0] align, ccr_t flags);
    instr_class_e cls;
    reg_addr_t    ra;
    byte_lanes_t  lanes;
    cls = expected_class(word);
    ra  = word[19:16];
    next_cycle();
    expect_idle();
    case (cls)
      class_nop: check_outputs("nop");
      class_cmp: begin
        dp_exp.ccr_write = 1'b1;
        dp_exp.alu_func  = `ALU_SUB;
        dp_mask.alu_func = '1;
        check_outputs("cmp");
      end
      class_unary: begin
        want_write(ra, unary_regsel(word[29:23]));
        check_outputs("unary");
      end
      class_ldiu: begin
        want_write(ra, `REGSEL_UIMM);
        check_outputs("ldiu");
      end
      class_branch: begin
        if (branch_taken(word[29:26], flags))
          dp_exp.pcsel = `PCSEL_BRANCH;
        check_outputs("branch");
      end
      class_alu_reg, class_alu_imm: begin
        dp_mask.alu_func = '1;
        if (cls == class_alu_reg) begin
          dp_exp.alu_func    = word[25:23];
          rf_exp.read_addr1  = word[15:12];
          rf_mask.read_addr1 = '1;
          rf_exp.read_addr2  = word[11:8];
          rf_mask.read_addr2 = '1;
        end else begin
          dp_exp.alu_func = word[26:24];
          want_offset(word[15:12]);
        end
        check_outputs("alu operands");
        next_cycle();
        want_write(ra, `REGSEL_ALU);
        check_outputs("alu write back");
      end
      class_load, class_store: begin
        lanes = expected_lanes(expected_size(word), align);
        want_offset(word[15:12]);
        check_outputs("address add");
        next_cycle();
        expect_idle();
        dp_exp.marsel  = `MARSEL_ALU;
        dp_mask.marsel = '1;
        dp_exp.mdrsel  = (cls == class_store) ? `MDRSEL_RA : 3'h0;
        dp_mask.mdrsel = '1;
        check_outputs("mar load");
        next_cycle();
        expect_idle();
        bus_exp.read        = (cls == class_load);
        bus_exp.write       = (cls == class_store);
        bus_exp.byteenable  = lanes;
        bus_mask.byteenable = '1;
        dp_exp.mdrsel       = (cls == class_load) ? `MDRSEL_BUS : 3'h0;
        dp_mask.mdrsel      = '1;
        dp_exp.addrsel      = 1'b1;
        dp_mask.addrsel     = 1'b1;
        check_bus_step("data transfer");
        next_cycle();
        expect_idle();
        if (cls == class_load)
          want_write(ra, `REGSEL_MDR);
        check_outputs("memory end");
      end
      class_jmp: begin
        want_offset(word[15:12]);
        check_outputs("jump target");
        next_cycle();
        expect_idle();
        dp_exp.pcsel = `PCSEL_ALU;
        check_outputs("jump");
      end
      class_trap: begin
        check_outputs("trap");
        push_pc_check(4'd8 + {1'b0, word[2:0]});
      end
      default: begin
        check_outputs("bad opcode");
        push_pc_check(`EXC_BAD_OPCODE);
      end
    endcase
  endtask

  task automatic run_word(instr_word_t word);
    logic [1:0] align;
    ccr_t       flags;
    align = 2'($urandom);
    flags = 4'($urandom);
    if (!hung) begin
      fetch_check(word, align, flags);
      execute_check(word, align, flags);
    end
  endtask

  task automatic interrupt_check(exc_cause_t irq);
    if (!hung) begin
      @(posedge clock);
      interrupt <= irq;
      @(negedge clock);
      expect_idle();
      bus_exp.read = 1'b1;
      check_outputs("interrupt sample");
      push_pc_check(irq);
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != errors_at_start || hung)
      tests_failed++;
    $display("test %-14s %0d errors%s", name, errors - errors_at_start,
             hung ? ", stopped by timeout" : "");
    errors_at_start = errors;
  endtask

  task automatic run_tests();
    instr_word_t word;
    opcode_t     ops [4];
    int          i;
    int          tries;
    expect_idle();
    check_outputs("reset state");
    vector_load_check();
    end_test("reset entry");
    for (i = 0; i < 4; i++) begin
      word = $urandom;
      word[31:23] = '0;                  // nop
      run_word(word);
    end
    end_test("fetch");
    ops = '{`OP_CMP, `OP_MOV, `OP_COM, `OP_NEG};
    for (i = 0; i < 20; i++) begin
      word = $urandom;
      if (i >= 16)
        word[31:23] = {`MODE_REG, ops[i - 16]};
      else if (i % 2 == 0)
        word[31:27] = {`MODE_REG, 3'b010};
      else
        word[31:28] = {`MODE_DIR, 2'b00};
      run_word(word);
    end
    word = $urandom;
    word[31:26] = {`MODE_IMM, 4'(`OP_LDIU)};
    run_word(word);
    end_test("alu and unary");
    for (i = 0; i < 26; i++) begin
      word = $urandom;
      if (i < 24)
        word[31:26] = {`MODE_IMM, 4'($urandom_range(0, 11))};
      else
        word[31:26] = {`MODE_REGIND, 4'(`OP_JMP)};
      run_word(word);
    end
    end_test("branch");
    for (i = 0; i < 16; i++) begin
      word = $urandom;
      word[31:26] = {`MODE_REGIND, 4'($urandom_range(0, 5))};
      run_word(word);
    end
    end_test("load store");
    for (i = 0; i < 3; i++) begin
      word  = $urandom;
      tries = 0;
      while (expected_class(word) != class_illegal && tries < 100) begin
        word = $urandom;
        tries++;
      end
      run_word(word);
      word = $urandom;
      word[31:24] = {`MODE_DIR, 6'(`OP_TRAP)};
      run_word(word);
      interrupt_check(4'($urandom_range(1, 7)));
    end
    word = '0;
    run_word(word);                      // fetch resumes after entry
    end_test("exceptions");
  endtask

  initial begin
    void'($urandom(32'h1bef27d6));
    clock           = 1'b0;
    reset_n         = 1'b0;
    ir              = '0;
    ccr             = '0;
    bus_wait        = 1'b0;
    interrupt       = '0;
    bus_align       = '0;
    cause_exp       = '0;
    wait_run        = 0;
    errors          = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    hung            = 1'b0;
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    run_tests();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (hung || errors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
+incdir+verification
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/branch_condition.sv
logic/ctrl_sequencer.sv
logic/cpu_control.sv
verification/tb_cpu_control.sv
